// ==== logic/exec_pkg.sv ====
package exec_pkg;

    localparam int DATA_W = 64;
    localparam int HALF_W = 32;

    typedef logic [DATA_W-1:0] word_t;

    // sub is shared with set-less-than
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_NOR = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,
        SRC2_SEXT = 2'd1,
        SRC2_ZEXT = 2'd2
    } src2_sel_e;

    // word moves applied after the shifter gives shifts of 32 and up
    typedef enum logic [1:0] {
        P32_NONE = 2'd0,
        P32_UP   = 2'd1,
        P32_DOWN = 2'd2
    } plus32_sel_e;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } inst_imm_t;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_reg_t;

    typedef union packed {
        inst_imm_t itype;
        inst_reg_t rtype;
    } inst_word_u;

    typedef struct packed {
        inst_word_u  inst;
        word_t       a_data;
        word_t       b_data;
        word_t       pc4;
        word_t       pc_branch;
        fwd_sel_e    forward_a;
        fwd_sel_e    forward_b;
        src2_sel_e   alu_src2;
        alu_op_e     alu_op;
        logic        slt;
        logic        cut_alu_out32;
        logic        shift_right;
        logic        shift_arith;
        logic        cut_shifter_out32;
        plus32_sel_e shifter_plus32;
        logic        alu_shifter_src;
        logic        lui;
        logic [4:0]  w_regnum;
        logic        write_enable;
        logic        mem_read;
        logic        word_we;
        logic        byte_we;
        logic        byte_load;
        logic        signed_byte;
        logic        beq;
        logic        bne;
    } id_regs_t;

    typedef struct packed {
        word_t      out;
        word_t      b_data;
        word_t      slt_out;
        word_t      pc4;
        word_t      pc_branch;
        logic [4:0] w_regnum;
        logic       overflow;
        logic       zero;
        logic [2:0] sel;
        logic       write_enable;
        logic       mem_read;
        logic       word_we;
        logic       byte_we;
        logic       byte_load;
        logic       signed_byte;
        logic       beq;
        logic       bne;
    } ex_regs_t;

    typedef struct packed {
        logic overflow;
        logic zero;
        logic negative;
    } alu_flags_t;

endpackage

// ==== logic/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward
    import exec_pkg::*;
(
    input  id_regs_t id_regs,
    input  word_t    ex_out,
    input  word_t    mem_data,
    output word_t    fwd_a,
    output word_t    fwd_b,
    output word_t    b_in
);

    word_t sign_ext_imm;
    word_t zero_ext_imm;

    // one forwarding mux serves both operands
    function automatic word_t pick_source(
        input fwd_sel_e sel,
        input word_t    reg_value,
        input word_t    ex_value,
        input word_t    mem_value
    );
        word_t picked;
        case (sel)
            FWD_EX:  picked = ex_value;
            FWD_MEM: picked = mem_value;
            default: picked = reg_value;
        endcase
        return picked;
    endfunction

    assign fwd_a = pick_source(id_regs.forward_a, id_regs.a_data, ex_out, mem_data);
    assign fwd_b = pick_source(id_regs.forward_b, id_regs.b_data, ex_out, mem_data);

    assign sign_ext_imm = {{(DATA_W-16){id_regs.inst.itype.imm16[15]}},
                           id_regs.inst.itype.imm16};
    assign zero_ext_imm = {{(DATA_W-16){1'b0}}, id_regs.inst.itype.imm16};

    always_comb begin
        case (id_regs.alu_src2)
            SRC2_SEXT: b_in = sign_ext_imm;
            SRC2_ZEXT: b_in = zero_ext_imm;
            // unused code falls back to the register operand
            default:   b_in = fwd_b;
        endcase
    end

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps

module int_alu
    import exec_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    alu_op,
    input  logic       cut_out32,
    output word_t      result,
    output alu_flags_t flags
);

    logic  subtract;
    logic  arith;
    word_t b_eff;
    word_t sum;
    word_t raw;

    // subtract shares the adder as a + ~b + 1
    assign subtract = (alu_op == ALU_SUB);
    assign arith    = (alu_op == ALU_ADD) || subtract;
    assign b_eff    = subtract ? ~b : b;
    assign sum      = a + b_eff + word_t'(subtract);

    always_comb begin
        case (alu_op)
            ALU_ADD: raw = sum;
            ALU_SUB: raw = sum;
            ALU_AND: raw = a & b;
            ALU_OR:  raw = a | b;
            ALU_XOR: raw = a ^ b;
            ALU_NOR: raw = ~(a | b);
            default: raw = sum;
        endcase
    end

    // signed overflow when operands agree in sign but the sum does not
    assign flags.overflow = arith
                          & (a[DATA_W-1] == b_eff[DATA_W-1])
                          & (sum[DATA_W-1] != a[DATA_W-1]);

    // flags look at the full width before any cut
    assign flags.zero     = (raw == '0);
    assign flags.negative = raw[DATA_W-1];

    assign result = cut_out32 ? {{HALF_W{raw[HALF_W-1]}}, raw[HALF_W-1:0]} : raw;

endmodule

// ==== logic/barrel_shifter.sv ====
`timescale 1ns/1ps

module barrel_shifter
    import exec_pkg::*;
(
    input  word_t       value,
    input  logic [4:0]  shamt,
    input  logic        shift_right,
    input  logic        shift_arith,
    input  logic        cut_out32,
    input  plus32_sel_e plus32,
    output word_t       result
);

    logic  fill;
    word_t stage [6];
    word_t cut;

    // arithmetic right shifts copy the top bit in
    assign fill     = shift_right & shift_arith & value[DATA_W-1];
    assign stage[0] = value;

    // stage k shifts by 2**k when shamt[k] is set
    for (genvar k = 0; k < 5; k++) begin : g_stage
        localparam int N = 1 << k;
        assign stage[k+1] = !shamt[k]   ? stage[k] :
                            shift_right ? {{N{fill}}, stage[k][DATA_W-1:N]} :
                                          {stage[k][DATA_W-1-N:0], {N{1'b0}}};
    end

    assign cut = cut_out32 ? {{HALF_W{stage[5][HALF_W-1]}}, stage[5][HALF_W-1:0]}
                           : stage[5];

    always_comb begin
        case (plus32)
            P32_UP:   result = {cut[HALF_W-1:0], {HALF_W{1'b0}}};
            P32_DOWN: result = {{HALF_W{1'b0}}, cut[DATA_W-1:HALF_W]};
            default:  result = cut;
        endcase
    end

endmodule

// ==== logic/ex_result_latch.sv ====
`timescale 1ns/1ps

module ex_result_latch
    import exec_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  id_regs_t   id_regs,
    input  word_t      alu_out,
    input  alu_flags_t alu_flags,
    input  word_t      shift_out,
    input  word_t      fwd_a,
    input  word_t      b_in,
    input  word_t      fwd_b,
    output ex_regs_t   ex_regs
);

    word_t    unit_out;
    word_t    lui_value;
    word_t    result;
    word_t    slt_value;
    logic     less_than;
    ex_regs_t next_regs;

    assign unit_out = id_regs.alu_shifter_src ? shift_out : alu_out;

    // imm16 lands in bits 31:16 and is sign-extended from bit 31
    assign lui_value = {{HALF_W{id_regs.inst.itype.imm16[15]}},
                        id_regs.inst.itype.imm16, 16'b0};
    assign result    = id_regs.lui ? lui_value : unit_out;

    // a < b when a is negative and b is not, or signs agree and a - b is negative
    assign less_than = (fwd_a[DATA_W-1] & ~b_in[DATA_W-1])
                     | ((fwd_a[DATA_W-1] == b_in[DATA_W-1]) & alu_flags.negative);
    assign slt_value = id_regs.slt ? {{(DATA_W-1){1'b0}}, less_than} : unit_out;

    always_comb begin
        next_regs.out          = result;
        next_regs.b_data       = fwd_b;
        next_regs.slt_out      = slt_value;
        next_regs.pc4          = id_regs.pc4;
        next_regs.pc_branch    = id_regs.pc_branch;
        next_regs.w_regnum     = id_regs.w_regnum;
        next_regs.overflow     = alu_flags.overflow;
        next_regs.zero         = alu_flags.zero;
        next_regs.sel          = id_regs.inst.rtype.funct[2:0];
        next_regs.write_enable = id_regs.write_enable;
        next_regs.mem_read     = id_regs.mem_read;
        next_regs.word_we      = id_regs.word_we;
        next_regs.byte_we      = id_regs.byte_we;
        next_regs.byte_load    = id_regs.byte_load;
        next_regs.signed_byte  = id_regs.signed_byte;
        next_regs.beq          = id_regs.beq;
        next_regs.bne          = id_regs.bne;
    end

    // flush turns the slot into a bubble
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_regs <= '0;
        end else if (flush) begin
            ex_regs <= '0;
        end else begin
            ex_regs <= next_regs;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import exec_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,
    input  id_regs_t id_regs,
    input  word_t    mem_data,
    output ex_regs_t ex_regs
);

    word_t      fwd_a;
    word_t      fwd_b;
    word_t      b_in;
    word_t      alu_out;
    word_t      shift_out;
    alu_flags_t alu_flags;

    // last registered result goes back as the execute forwarding source
    operand_forward u_operand_forward (
        .id_regs  (id_regs),
        .ex_out   (ex_regs.out),
        .mem_data (mem_data),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .b_in     (b_in)
    );

    int_alu u_int_alu (
        .a         (fwd_a),
        .b         (b_in),
        .alu_op    (id_regs.alu_op),
        .cut_out32 (id_regs.cut_alu_out32),
        .result    (alu_out),
        .flags     (alu_flags)
    );

    barrel_shifter u_barrel_shifter (
        .value       (fwd_b),
        .shamt       (id_regs.inst.rtype.shamt),
        .shift_right (id_regs.shift_right),
        .shift_arith (id_regs.shift_arith),
        .cut_out32   (id_regs.cut_shifter_out32),
        .plus32      (id_regs.shifter_plus32),
        .result      (shift_out)
    );

    ex_result_latch u_ex_result_latch (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .id_regs   (id_regs),
        .alu_out   (alu_out),
        .alu_flags (alu_flags),
        .shift_out (shift_out),
        .fwd_a     (fwd_a),
        .b_in      (b_in),
        .fwd_b     (fwd_b),
        .ex_regs   (ex_regs)
    );

endmodule

// ==== test/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic word_t model_forward(
    input fwd_sel_e sel,
    input word_t    reg_value,
    input word_t    ex_value,
    input word_t    mem_value
);
    if (sel == FWD_EX) return ex_value;
    if (sel == FWD_MEM) return mem_value;
    return reg_value;
endfunction

function automatic word_t model_sext32(input word_t v);
    return {{32{v[31]}}, v[31:0]};
endfunction

function automatic word_t model_alu_raw(input alu_op_e op, input word_t a, input word_t b);
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_NOR: return ~(a | b);
        default: return a + b;
    endcase
endfunction

// signed overflow of add or subtract only
function automatic logic model_overflow(
    input alu_op_e op,
    input word_t   a,
    input word_t   b,
    input word_t   r
);
    if (op == ALU_ADD) return (a[63] == b[63]) && (r[63] != a[63]);
    if (op == ALU_SUB) return (a[63] != b[63]) && (r[63] != a[63]);
    return 1'b0;
endfunction

function automatic word_t model_shift(input word_t v, input logic [4:0] amt,
                                      input logic right, input logic arith,
                                      input logic cut, input plus32_sel_e plus32);
    word_t r;
    if (!right) r = v << amt;
    else if (arith) r = word_t'($signed(v) >>> amt);
    else r = v >> amt;
    if (cut) r = model_sext32(r);
    // word moves give the shifts of 32 to 63
    if (plus32 == P32_UP) r = {r[31:0], 32'h0};
    else if (plus32 == P32_DOWN) r = {32'h0, r[63:32]};
    return r;
endfunction

function automatic ex_regs_t model_execute(input id_regs_t id, input word_t mem,
                                           input ex_regs_t prev, input logic flush);
    ex_regs_t   e;
    word_t      a;
    word_t      b_reg;
    word_t      b_op;
    word_t      raw;
    word_t      alu_res;
    word_t      sh;
    word_t      unit;
    logic [15:0] imm;
    e = '0;
    if (flush) return e;
    imm   = id.inst.itype.imm16;
    a     = model_forward(id.forward_a, id.a_data, prev.out, mem);
    b_reg = model_forward(id.forward_b, id.b_data, prev.out, mem);
    if (id.alu_src2 == SRC2_SEXT) b_op = {{48{imm[15]}}, imm};
    else if (id.alu_src2 == SRC2_ZEXT) b_op = {48'h0, imm};
    else b_op = b_reg;
    raw     = model_alu_raw(id.alu_op, a, b_op);
    alu_res = id.cut_alu_out32 ? model_sext32(raw) : raw;
    sh      = model_shift(b_reg, id.inst.rtype.shamt, id.shift_right, id.shift_arith,
                          id.cut_shifter_out32, id.shifter_plus32);
    unit    = id.alu_shifter_src ? sh : alu_res;
    e.out       = id.lui ? {{32{imm[15]}}, imm, 16'h0} : unit;
    e.slt_out   = id.slt ? {63'h0, ($signed(a) < $signed(b_op))} : unit;
    e.b_data    = b_reg;
    e.pc4       = id.pc4;
    e.pc_branch = id.pc_branch;
    e.w_regnum  = id.w_regnum;
    e.overflow  = model_overflow(id.alu_op, a, b_op, raw);
    e.zero      = (raw == '0);
    e.sel       = id.inst.rtype.funct[2:0];
    e.write_enable = id.write_enable;
    e.mem_read     = id.mem_read;
    e.word_we      = id.word_we;
    e.byte_we      = id.byte_we;
    e.byte_load    = id.byte_load;
    e.signed_byte  = id.signed_byte;
    e.beq          = id.beq;
    e.bne          = id.bne;
    return e;
endfunction

`endif

// ==== test/execute_tb.sv ====
`timescale 1ns/1ps

module execute_tb
    import exec_pkg::*;
;

    `include "exec_model.svh"

    localparam int TEST_CYCLES = 200;
    localparam int NUM_TESTS   = 6;
    localparam int RESET_CYCLES = 16;
    // every cycle is 40 ns plus some slack
    localparam int TIMEOUT_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 10) * 40 + 1000;

    logic     clock;
    logic     reset;
    logic     flush;
    id_regs_t id_regs;
    word_t    mem_data;
    ex_regs_t ex_regs;

    logic [31:0] lfsr_state;
    ex_regs_t    prev_exp;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    execute_stage dut (
        .clock    (clock),
        .reset    (reset),
        .flush    (flush),
        .id_regs  (id_regs),
        .mem_data (mem_data),
        .ex_regs  (ex_regs)
    );

    always #20 clock = ~clock;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // 0 to 2 with code 3 folded onto 0
    function automatic logic [1:0] pick3();
        logic [1:0] v;
        v = take_bits(2);
        return (v == 2'd3) ? 2'd0 : v;
    endfunction

    function automatic logic [2:0] pick_op();
        logic [2:0] v;
        v = take_bits(3);
        return (v > 3'd5) ? v - 3'd4 : v;
    endfunction

    task automatic make_stimulus(input int mode, input int cycle, output id_regs_t id,
                                 output word_t mem, output logic fl);
        id = '0;
        id.inst      = take_bits(32);
        id.a_data    = take_bits(64);
        id.b_data    = take_bits(64);
        id.pc4       = take_bits(64);
        id.pc_branch = take_bits(64);
        mem          = take_bits(64);
        id.alu_op            = alu_op_e'(pick_op());
        id.cut_alu_out32     = take_bits(1);
        id.shift_right       = take_bits(1);
        id.shift_arith       = take_bits(1);
        id.cut_shifter_out32 = take_bits(1);
        id.shifter_plus32    = plus32_sel_e'(pick3());
        id.w_regnum          = take_bits(5);
        id.write_enable      = take_bits(1);
        id.mem_read          = take_bits(1);
        id.word_we           = take_bits(1);
        id.byte_we           = take_bits(1);
        id.byte_load         = take_bits(1);
        id.signed_byte       = take_bits(1);
        id.beq               = take_bits(1);
        id.bne               = take_bits(1);
        fl = 1'b0;
        case (mode)
            2: id.alu_src2 = take_bits(1) ? SRC2_ZEXT : SRC2_SEXT;
            3: begin
                id.alu_shifter_src = 1'b1;
                id.inst.rtype.shamt = cycle[4:0];
            end
            4: begin
                id.slt = take_bits(1);
                id.lui = take_bits(1);
                id.alu_shifter_src = take_bits(1);
                // equal operands now and then
                if (take_bits(2) == 0) id.b_data = id.a_data;
            end
            5: begin
                id.forward_a = fwd_sel_e'(pick3());
                id.forward_b = fwd_sel_e'(pick3());
                id.alu_src2  = src2_sel_e'(pick3());
                id.alu_shifter_src = take_bits(1);
            end
            6: begin
                id.forward_a = fwd_sel_e'(pick3());
                id.forward_b = fwd_sel_e'(pick3());
                id.alu_src2  = src2_sel_e'(pick3());
                id.alu_shifter_src = take_bits(1);
                id.slt = take_bits(1);
                id.lui = take_bits(1);
                fl = (take_bits(2) == 0);
            end
            default: ;
        endcase
        // set-less-than relies on the subtract
        if (id.slt) id.alu_op = ALU_SUB;
    endtask

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns ex_regs.%s expected %h actual %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_record(input ex_regs_t e, input ex_regs_t a);
        check_field("out", e.out, a.out);
        check_field("b_data", e.b_data, a.b_data);
        check_field("slt_out", e.slt_out, a.slt_out);
        check_field("pc4", e.pc4, a.pc4);
        check_field("pc_branch", e.pc_branch, a.pc_branch);
        check_field("w_regnum", e.w_regnum, a.w_regnum);
        check_field("overflow", e.overflow, a.overflow);
        check_field("zero", e.zero, a.zero);
        check_field("sel", e.sel, a.sel);
        check_field("write_enable", e.write_enable, a.write_enable);
        check_field("mem_read", e.mem_read, a.mem_read);
        check_field("word_we", e.word_we, a.word_we);
        check_field("byte_we", e.byte_we, a.byte_we);
        check_field("byte_load", e.byte_load, a.byte_load);
        check_field("signed_byte", e.signed_byte, a.signed_byte);
        check_field("beq", e.beq, a.beq);
        check_field("bne", e.bne, a.bne);
    endtask

    task automatic report_test(input string name, input int cycles, input int errors);
        tests_run++;
        if (errors == 0) begin
            $display("test %s: %0d cycles, passed", name, cycles);
        end else begin
            tests_failed++;
            $display("test %s: %0d cycles, %0d errors, failed", name, cycles, errors);
        end
    endtask

    task automatic run_test(input string name, input int mode, input int cycles);
        int       first_errors;
        id_regs_t id;
        word_t    mem;
        logic     fl;
        ex_regs_t exp;
        first_errors = error_count;
        for (int i = 0; i < cycles; i++) begin
            make_stimulus(mode, i, id, mem, fl);
            id_regs  = id;
            mem_data = mem;
            flush    = fl;
            exp = model_execute(id, mem, prev_exp, fl);
            @(posedge clock);
            #2;
            compare_record(exp, ex_regs);
            prev_exp = exp;
        end
        report_test(name, cycles, error_count - first_errors);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("error: watchdog expired, the run timed out before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int first_errors;
        clock        = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        id_regs      = '0;
        mem_data     = '0;
        lfsr_state   = 32'd82081;
        prev_exp     = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        first_errors = error_count;
        compare_record('0, ex_regs);
        report_test("reset", RESET_CYCLES, error_count - first_errors);

        run_test("alu_reg", 1, TEST_CYCLES);
        run_test("alu_imm", 2, TEST_CYCLES);
        run_test("shift", 3, TEST_CYCLES);
        run_test("slt_lui", 4, TEST_CYCLES);
        run_test("forward", 5, TEST_CYCLES);
        run_test("flush_ctrl", 6, TEST_CYCLES);

        $display("tests run %0d, passed %0d, failed %0d, value errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+test
logic/exec_pkg.sv
logic/operand_forward.sv
logic/int_alu.sv
logic/barrel_shifter.sv
logic/ex_result_latch.sv
logic/execute_stage.sv
test/execute_tb.sv
